/* Makefile */
# Verilator build and run of the descriptor front end testbench.

SIM := obj_dir/Vdesc64_tb

.PHONY: all run lint clean

all: run

$(SIM): project.f rtl/*.sv rtl/*.svh bench/*.sv
	verilator --binary --timing -f project.f --top-module desc64_tb -Mdir obj_dir

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module desc64_tb
	verilator --lint-only -Wall +incdir+rtl rtl/desc64_pkg.sv rtl/desc64_reg_if.sv \
		rtl/desc64_reg_file.sv rtl/desc64_reg_wrapper.sv rtl/desc64_desc_fifo.sv \
		rtl/desc64_frontend_top.sv --top-module desc64_frontend_top

clean:
	rm -rf obj_dir sim.log

/* bench/desc64_checker.sv */
//////////////////////////////
// checker of the front end: register responses,
// descriptor order, queue level and done count.
//////////////////////////////

`timescale 1ns/1ps
`include "desc64_cfg.svh"

module desc64_checker (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   reg_valid_i,
    input  logic                   reg_write_i,
    input  desc64_pkg::reg_addr_t  reg_addr_i,
    input  desc64_pkg::reg_data_t  reg_wdata_i,
    input  logic                   reg_ready_i,
    input  logic                   reg_error_i,
    input  desc64_pkg::reg_data_t  reg_rdata_i,
    input  logic                   desc_valid_i,
    input  desc64_pkg::desc_addr_t desc_addr_i,
    input  logic                   desc_ready_i,
    input  logic                   desc_done_i,
    output logic                   idle_o,
    output int                     reg_errs_o,
    output int                     desc_errs_o,
    output int                     flow_errs_o
);

    localparam desc64_pkg::fifo_level_t DEPTH = `DESC64_FIFO_DEPTH;

    string                   step_name = "none";
    desc64_pkg::reg_data_t   exp_rdata = '0;
    logic                    exp_error = 1'b0;
    desc64_pkg::desc_addr_t  desc_q [$];        // accepted on the bus, not yet popped.
    desc64_pkg::fifo_level_t level_m;           // entries held in the FIFO.
    logic                    pending_m;         // push strobe or held push.
    desc64_pkg::done_cnt_t   done_m;
    int                      reg_errs = 0;
    int                      desc_errs = 0;
    int                      flow_errs = 0;

    assign reg_errs_o  = reg_errs;
    assign desc_errs_o = desc_errs;
    assign flow_errs_o = flow_errs;

    // expectations of the access now on the bus.
    task automatic set_step(input string name, input desc64_pkg::reg_data_t rdata,
                            input logic error);
        step_name = name;
        exp_rdata = rdata;
        exp_error = error;
    endtask

    // status and done count come from the model, the rest from the table.
    function automatic desc64_pkg::reg_data_t expected_read(input desc64_pkg::reg_addr_t addr);
        if (addr == `DESC64_STATUS_OFFSET) begin
            return {{(`DESC64_DW-4){1'b0}}, level_m == DEPTH, level_m};
        end
        if (addr == `DESC64_DONE_CNT_OFFSET) begin
            return {{(`DESC64_DW-32){1'b0}}, done_m};
        end
        return exp_rdata;
    endfunction

    always @(posedge clk_i or negedge arst_n_i) begin : watch
        logic is_desc;
        logic exp_ready;
        logic push;
        logic pop;
        logic accept_desc;
        if (!arst_n_i) begin
            desc_q.delete();
            level_m   = '0;
            pending_m = 1'b0;
            done_m    = '0;
            idle_o    = 1'b1;
        end else begin
            is_desc     = (reg_addr_i == `DESC64_DESC_ADDR_OFFSET);
            push        = pending_m && (level_m < DEPTH);
            pop         = desc_valid_i && desc_ready_i;
            exp_ready   = is_desc ? ((level_m < DEPTH) && !pending_m) : 1'b1;
            accept_desc = reg_valid_i && reg_ready_i && reg_write_i && is_desc;

            //////////////////////////////
            // register bus
            //////////////////////////////
            if (reg_valid_i && reg_ready_i !== exp_ready) begin
                flow_errs++;
                $display("[FAIL] %s: ready expected %b actual %b", step_name, exp_ready,
                         reg_ready_i);
            end
            if (reg_valid_i && reg_ready_i) begin
                if (reg_error_i !== exp_error) begin
                    reg_errs++;
                    $display("[FAIL] %s: error expected %b actual %b", step_name, exp_error,
                             reg_error_i);
                end
                if (!reg_write_i && reg_rdata_i !== expected_read(reg_addr_i)) begin
                    reg_errs++;
                    $display("[FAIL] %s: read data expected %h actual %h", step_name,
                             expected_read(reg_addr_i), reg_rdata_i);
                end
            end
            if (accept_desc) begin
                desc_q.push_back(reg_wdata_i);
            end

            //////////////////////////////
            // descriptor output
            //////////////////////////////
            if (desc_valid_i !== (level_m != '0)) begin
                flow_errs++;
                $display("[FAIL] desc_valid: expected %b actual %b", level_m != '0,
                         desc_valid_i);
            end
            if (pop) begin
                if (desc_q.size() == 0) begin
                    desc_errs++;
                    $display("descriptor %h came out with no matching register write",
                             desc_addr_i);
                end else begin
                    if (desc_addr_i !== desc_q[0]) begin
                        desc_errs++;
                        $display("[FAIL] descriptor_order: expected %h actual %h", desc_q[0],
                                 desc_addr_i);
                    end
                    void'(desc_q.pop_front());
                end
            end

            // state after this edge.
            if (push && !pop) begin
                level_m = level_m + 1'b1;
            end else if (pop && !push && level_m != '0) begin
                level_m = level_m - 1'b1;
            end
            pending_m = accept_desc || (pending_m && !push);
            if (desc_done_i) begin
                done_m = done_m + 1'b1;
            end
            idle_o = (desc_q.size() == 0) && !pending_m;
        end
    end

endmodule

/* bench/desc64_tb.sv */
//////////////////////////////
// testbench of the descriptor front end: clock,
// reset, stimulus table, fetcher model, watchdog.
//////////////////////////////

`timescale 1ns/1ps
`include "desc64_cfg.svh"

module desc64_tb;

    localparam int OP_ACCESS      = 0;
    localparam int OP_DRAIN       = 1;   // wait until every descriptor is done.
    localparam int CYCLES_PER_ROW = 50;

    logic                   clk;
    logic                   arst_n;
    logic                   devmode;
    logic                   reg_valid;
    logic                   reg_write;
    desc64_pkg::reg_addr_t  reg_addr;
    desc64_pkg::reg_data_t  reg_wdata;
    desc64_pkg::reg_strb_t  reg_wstrb;
    logic                   reg_ready;
    logic                   reg_error;
    desc64_pkg::reg_data_t  reg_rdata;
    logic                   desc_valid;
    desc64_pkg::desc_addr_t desc_addr;
    logic                   desc_ready;
    logic                   desc_done;
    logic                   chk_idle;
    int                     reg_errs;
    int                     desc_errs;
    int                     flow_errs;
    logic                   fetch_hold = 1'b0;   // fetcher refuses descriptors.
    logic                   popped_q = 1'b0;
    logic [31:0]            lcg_state;
    bit                     table_ready = 1'b0;

    //////////////////////////////
    // stimulus table
    //////////////////////////////
    string                 row_name  [$];
    int                    row_op    [$];
    logic                  row_wr    [$];
    desc64_pkg::reg_addr_t row_addr  [$];
    desc64_pkg::reg_data_t row_data  [$];
    desc64_pkg::reg_strb_t row_strb  [$];
    logic                  row_dev   [$];
    desc64_pkg::reg_data_t row_rdata [$];
    logic                  row_err   [$];
    int                    row_hold  [$];   // 0 free, -1 held, n held for n cycles.

    desc64_frontend_top u_dut (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .devmode_i    (devmode),
        .reg_valid_i  (reg_valid),
        .reg_write_i  (reg_write),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_wstrb_i  (reg_wstrb),
        .reg_ready_o  (reg_ready),
        .reg_error_o  (reg_error),
        .reg_rdata_o  (reg_rdata),
        .desc_valid_o (desc_valid),
        .desc_addr_o  (desc_addr),
        .desc_ready_i (desc_ready),
        .desc_done_i  (desc_done)
    );

    desc64_checker u_chk (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .reg_valid_i  (reg_valid),
        .reg_write_i  (reg_write),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_ready_i  (reg_ready),
        .reg_error_i  (reg_error),
        .reg_rdata_i  (reg_rdata),
        .desc_valid_i (desc_valid),
        .desc_addr_i  (desc_addr),
        .desc_ready_i (desc_ready),
        .desc_done_i  (desc_done),
        .idle_o       (chk_idle),
        .reg_errs_o   (reg_errs),
        .desc_errs_o  (desc_errs),
        .flow_errs_o  (flow_errs)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input string name, input int op, input logic wr,
                           input desc64_pkg::reg_addr_t addr, input desc64_pkg::reg_data_t data,
                           input desc64_pkg::reg_strb_t strb, input logic dev,
                           input desc64_pkg::reg_data_t rdata, input logic err, input int hold);
        row_name.push_back(name);
        row_op.push_back(op);
        row_wr.push_back(wr);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_strb.push_back(strb);
        row_dev.push_back(dev);
        row_rdata.push_back(rdata);
        row_err.push_back(err);
        row_hold.push_back(hold);
    endtask

    task automatic add_write(input string name, input desc64_pkg::reg_addr_t addr,
                             input desc64_pkg::reg_data_t data, input desc64_pkg::reg_strb_t strb,
                             input logic dev, input logic err, input int hold);
        add_row(name, OP_ACCESS, 1'b1, addr, data, strb, dev, '0, err, hold);
    endtask

    task automatic add_read(input string name, input desc64_pkg::reg_addr_t addr, input logic dev,
                            input desc64_pkg::reg_data_t rdata, input logic err, input int hold);
        add_row(name, OP_ACCESS, 1'b0, addr, '0, '0, dev, rdata, err, hold);
    endtask

    task automatic build_table();
        desc64_pkg::reg_data_t rnd;
        add_read ("reset_status", `DESC64_STATUS_OFFSET, 1'b0, '0, 1'b0, 0);
        add_read ("reset_done_cnt", `DESC64_DONE_CNT_OFFSET, 1'b0, '0, 1'b0, 0);
        add_write("conf_wr_full", `DESC64_CONF_OFFSET, 64'h0123_4567_89ab_cdef, 8'hff, 0, 0, 0);
        add_read ("conf_rd_full", `DESC64_CONF_OFFSET, 1'b0, 64'h0123_4567_89ab_cdef, 1'b0, 0);
        add_write("conf_wr_low", `DESC64_CONF_OFFSET, 64'hffee_ddcc_bbaa_9988, 8'h0f, 0, 0, 0);
        add_read ("conf_rd_low", `DESC64_CONF_OFFSET, 1'b0, 64'h0123_4567_bbaa_9988, 1'b0, 0);
        add_write("conf_wr_high", `DESC64_CONF_OFFSET, 64'h7766_5544_3322_1100, 8'hc0, 0, 0, 0);
        add_read ("conf_rd_high", `DESC64_CONF_OFFSET, 1'b0, 64'h7766_4567_bbaa_9988, 1'b0, 0);
        add_write("conf_wr_none", `DESC64_CONF_OFFSET, 64'hdead_beef_dead_beef, 8'h00, 0, 0, 0);
        add_read ("conf_rd_none", `DESC64_CONF_OFFSET, 1'b0, 64'h7766_4567_bbaa_9988, 1'b0, 0);
        add_write("status_wr", `DESC64_STATUS_OFFSET, 64'h0f, 8'hff, 0, 0, 0);
        add_read ("status_rd_after_wr", `DESC64_STATUS_OFFSET, 1'b0, '0, 1'b0, 0);
        add_write("done_wr", `DESC64_DONE_CNT_OFFSET, 64'h55, 8'hff, 0, 0, 0);
        add_read ("done_rd_after_wr", `DESC64_DONE_CNT_OFFSET, 1'b0, '0, 1'b0, 0);
        add_read ("unknown_rd_user", 8'h20, 1'b0, '0, 1'b0, 0);
        add_write("unknown_wr_user", 8'h28, 64'h1234, 8'hff, 0, 0, 0);
        add_read ("unknown_rd_dev", 8'h20, 1'b1, '0, 1'b1, 0);
        add_write("unknown_wr_dev", 8'h30, 64'h5678, 8'hff, 1, 1, 0);
        add_read ("conf_rd_dev", `DESC64_CONF_OFFSET, 1'b1, 64'h7766_4567_bbaa_9988, 1'b0, 0);
        add_read ("desc_rd_zero", `DESC64_DESC_ADDR_OFFSET, 1'b0, '0, 1'b0, 0);
        // back-pressure with the fetcher stalled.
        for (int i = 0; i < 4; i++) begin
            add_write($sformatf("bp_desc%0d", i), `DESC64_DESC_ADDR_OFFSET,
                      64'h1000_0000_0000_0000 | (64'(i) << 6), 8'hff, 0, 0, -1);
        end
        // the last push lands while this read is on the bus.
        add_read ("bp_status_level", `DESC64_STATUS_OFFSET, 1'b0, '0, 1'b0, -1);
        add_read ("bp_status_full", `DESC64_STATUS_OFFSET, 1'b0, '0, 1'b0, -1);
        add_read ("bp_conf_rd", `DESC64_CONF_OFFSET, 1'b0, 64'h7766_4567_bbaa_9988, 1'b0, -1);
        add_write("bp_desc_stall", `DESC64_DESC_ADDR_OFFSET, 64'h1000_0000_0000_0100,
                  8'hff, 0, 0, 8);
        for (int i = 0; i < 12; i++) begin
            lcg_state  = lcg_next(lcg_state);
            rnd[63:32] = lcg_state;
            lcg_state  = lcg_next(lcg_state);
            rnd[31:0]  = lcg_state;
            add_write($sformatf("rand_desc%0d", i), `DESC64_DESC_ADDR_OFFSET, rnd,
                      8'hff, 0, 0, 0);
            if (i % 3 == 2) begin
                add_read($sformatf("rand_status%0d", i), `DESC64_STATUS_OFFSET, 0, '0, 0, 0);
                add_read($sformatf("rand_done%0d", i), `DESC64_DONE_CNT_OFFSET, 0, '0, 0, 0);
            end
        end
        add_row("drain", OP_DRAIN, 1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 0);
        add_read ("final_done_cnt", `DESC64_DONE_CNT_OFFSET, 1'b0, '0, 1'b0, 0);
        add_read ("final_status", `DESC64_STATUS_OFFSET, 1'b0, '0, 1'b0, 0);
    endtask

    // presents one row and holds it until the handshake.
    task automatic apply_row(input int idx);
        int waited;
        bit taken;
        waited     = 0;
        taken      = 1'b0;
        fetch_hold = (row_hold[idx] != 0);    // seen by the fetcher at the next falling edge.
        @(negedge clk);
        if (row_op[idx] == OP_DRAIN) begin
            reg_valid = 1'b0;
            while (!chk_idle) begin
                @(negedge clk);
            end
            repeat (3) @(negedge clk);          // last done pulse reaches the counter.
        end else begin
            u_chk.set_step(row_name[idx], row_rdata[idx], row_err[idx]);
            devmode   = row_dev[idx];
            reg_valid = 1'b1;
            reg_write = row_wr[idx];
            reg_addr  = row_addr[idx];
            reg_wdata = row_data[idx];
            reg_wstrb = row_strb[idx];
            while (!taken) begin
                @(posedge clk);
                waited++;
                if (reg_ready) begin
                    taken = 1'b1;
                end else if (row_hold[idx] > 0 && waited == row_hold[idx]) begin
                    fetch_hold = 1'b0;          // let the queue drain.
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // fetcher model
    //////////////////////////////
    always @(posedge clk) begin
        popped_q <= desc_valid && desc_ready;
    end

    initial begin
        desc_ready = 1'b0;
        desc_done  = 1'b0;
        @(posedge arst_n);
        forever begin
            @(negedge clk);
            desc_done  = popped_q;             // one pulse per accepted descriptor.
            lcg_state  = lcg_next(lcg_state);
            desc_ready = !fetch_hold && (lcg_state[31:30] != 2'b00);
        end
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = row_name.size() * CYCLES_PER_ROW;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int total;
        arst_n    = 1'b0;
        devmode   = 1'b0;
        reg_valid = 1'b0;
        reg_write = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        reg_wstrb = '0;
        lcg_state = 32'h6808429c;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < row_name.size(); i++) begin
            apply_row(i);
        end
        @(negedge clk);
        reg_valid = 1'b0;
        repeat (2) @(negedge clk);
        total = reg_errs + desc_errs + flow_errs;
        $display("errors: register %0d, descriptor %0d, flow %0d", reg_errs, desc_errs,
                 flow_errs);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+rtl
rtl/desc64_pkg.sv
rtl/desc64_reg_if.sv
rtl/desc64_reg_file.sv
rtl/desc64_reg_wrapper.sv
rtl/desc64_desc_fifo.sv
rtl/desc64_frontend_top.sv
bench/desc64_checker.sv
bench/desc64_tb.sv

/* rtl/desc64_cfg.svh */
//////////////////////////////
// register bus widths, register offsets and
// descriptor queue depth of the DMA front end.
//////////////////////////////

`ifndef DESC64_CFG_SVH
`define DESC64_CFG_SVH

// register bus.
`define DESC64_DW                 64     // data width in bits.
`define DESC64_AW                 8      // byte address width.

// register map, byte offsets.
`define DESC64_CONF_OFFSET        8'h00
`define DESC64_STATUS_OFFSET      8'h08
`define DESC64_DESC_ADDR_OFFSET   8'h10
`define DESC64_DONE_CNT_OFFSET    8'h18

`define DESC64_FIFO_DEPTH         4      // descriptor queue entries.

`endif

/* rtl/desc64_desc_fifo.sv */
//////////////////////////////
// descriptor address FIFO with valid/ready on
// both sides and a fill level output.
//////////////////////////////

`timescale 1ns/1ps
`include "desc64_cfg.svh"

module desc64_desc_fifo (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    push_valid_i,
    output logic                    push_ready_o,
    input  desc64_pkg::desc_addr_t  push_addr_i,
    output logic                    pop_valid_o,
    input  logic                    pop_ready_i,
    output desc64_pkg::desc_addr_t  pop_addr_o,
    output desc64_pkg::fifo_level_t level_o
);

    localparam int PTR_W = $clog2(`DESC64_FIFO_DEPTH);

    desc64_pkg::desc_addr_t  mem_q [`DESC64_FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    desc64_pkg::fifo_level_t level_q;
    logic                    do_push;
    logic                    do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`DESC64_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ready_o = (level_q < `DESC64_FIFO_DEPTH);
    assign pop_valid_o  = (level_q != '0);
    assign pop_addr_o   = mem_q[rd_ptr_q];   // head entry.
    assign level_o      = level_q;

    assign do_push = push_valid_i && push_ready_o;
    assign do_pop  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_addr_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;      // both or neither.
            endcase
        end
    end

endmodule

/* rtl/desc64_frontend_top.sv */
//////////////////////////////
// top level of the DMA descriptor front end.
//////////////////////////////

`timescale 1ns/1ps

module desc64_frontend_top (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   devmode_i,
    input  logic                   reg_valid_i,
    input  logic                   reg_write_i,
    input  desc64_pkg::reg_addr_t  reg_addr_i,
    input  desc64_pkg::reg_data_t  reg_wdata_i,
    input  desc64_pkg::reg_strb_t  reg_wstrb_i,
    output logic                   reg_ready_o,
    output logic                   reg_error_o,
    output desc64_pkg::reg_data_t  reg_rdata_o,
    output logic                   desc_valid_o,
    output desc64_pkg::desc_addr_t desc_addr_o,
    input  logic                   desc_ready_i,
    input  logic                   desc_done_i
);

    desc64_reg_if outer_bus ();
    desc64_reg_if inner_bus ();

    logic                    desc_push_valid;
    logic                    desc_push_ready;
    desc64_pkg::desc_addr_t  desc_push_addr;
    logic                    desc_addr_qe;
    desc64_pkg::fifo_level_t fifo_level;

    // outer bus from the top-level ports.
    assign outer_bus.valid = reg_valid_i;
    assign outer_bus.addr  = reg_addr_i;
    assign outer_bus.write = reg_write_i;
    assign outer_bus.wdata = reg_wdata_i;
    assign outer_bus.wstrb = reg_wstrb_i;
    assign reg_ready_o     = outer_bus.ready;
    assign reg_rdata_o     = outer_bus.rdata;
    assign reg_error_o     = outer_bus.error;

    desc64_reg_wrapper u_wrapper (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .outer             (outer_bus.completer),
        .inner             (inner_bus.requester),
        .desc_addr_qe_i    (desc_addr_qe),
        .desc_push_ready_i (desc_push_ready),
        .desc_push_valid_o (desc_push_valid)
    );

    desc64_reg_file u_reg_file (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .bus            (inner_bus.completer),
        .devmode_i      (devmode_i),
        .desc_addr_o    (desc_push_addr),
        .desc_addr_qe_o (desc_addr_qe),
        .fifo_level_i   (fifo_level),
        .desc_done_i    (desc_done_i)
    );

    desc64_desc_fifo u_fifo (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_valid_i (desc_push_valid),
        .push_ready_o (desc_push_ready),
        .push_addr_i  (desc_push_addr),
        .pop_valid_o  (desc_valid_o),
        .pop_ready_i  (desc_ready_i),
        .pop_addr_o   (desc_addr_o),
        .level_o      (fifo_level)
    );

endmodule

/* rtl/desc64_pkg.sv */
//////////////////////////////
// shared types of the front end: register data,
// address, strobes, descriptor address, counters.
//////////////////////////////

`include "desc64_cfg.svh"

package desc64_pkg;

    //////////////////////////////
    // register bus
    //////////////////////////////

    typedef logic [`DESC64_DW-1:0]     reg_data_t;   // read and write data.
    typedef logic [`DESC64_AW-1:0]     reg_addr_t;   // byte address.
    typedef logic [`DESC64_DW/8-1:0]   reg_strb_t;   // one bit per data byte.

    //////////////////////////////
    // descriptor path
    //////////////////////////////

    // descriptors live in a 64-bit memory space.
    typedef logic [`DESC64_DW-1:0]     desc_addr_t;

    typedef logic [31:0]               done_cnt_t;   // completed descriptors.

    // needs to hold 0 up to the full depth.
    typedef logic [$clog2(`DESC64_FIFO_DEPTH+1)-1:0] fifo_level_t;

endpackage

/* rtl/desc64_reg_file.sv */
//////////////////////////////
// register file of the front end: configuration,
// status, descriptor address and done counter.
//////////////////////////////

`timescale 1ns/1ps
`include "desc64_cfg.svh"

module desc64_reg_file (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    desc64_reg_if.completer         bus,
    input  logic                    devmode_i,
    output desc64_pkg::desc_addr_t  desc_addr_o,
    output logic                    desc_addr_qe_o,
    input  desc64_pkg::fifo_level_t fifo_level_i,
    input  logic                    desc_done_i
);

    desc64_pkg::reg_data_t  conf_q;
    desc64_pkg::desc_addr_t desc_addr_q;
    logic                   desc_addr_qe_q;
    desc64_pkg::done_cnt_t  done_cnt_q;
    desc64_pkg::reg_data_t  status_val;
    logic                   fifo_full;
    logic                   known_addr;
    logic                   wr_en;
    logic                   conf_wr;
    logic                   desc_wr;

    //////////////////////////////
    // decode
    //////////////////////////////

    assign bus.ready = 1'b1;                      // never stalls by itself.
    assign wr_en     = bus.valid && bus.write;
    assign conf_wr   = wr_en && (bus.addr == `DESC64_CONF_OFFSET);
    assign desc_wr   = wr_en && (bus.addr == `DESC64_DESC_ADDR_OFFSET);

    assign fifo_full  = (fifo_level_i == desc64_pkg::fifo_level_t'(`DESC64_FIFO_DEPTH));
    assign status_val = {{(`DESC64_DW-4){1'b0}}, fifo_full, fifo_level_i};

    always_comb begin
        known_addr = 1'b1;
        bus.rdata  = '0;
        case (bus.addr)
            `DESC64_CONF_OFFSET:      bus.rdata = conf_q;
            `DESC64_STATUS_OFFSET:    bus.rdata = status_val;
            `DESC64_DESC_ADDR_OFFSET: bus.rdata = '0;   // write-only register.
            `DESC64_DONE_CNT_OFFSET:  bus.rdata = desc64_pkg::reg_data_t'(done_cnt_q);
            default:                  known_addr = 1'b0;
        endcase
    end

    // unknown offsets are only flagged in developer mode.
    assign bus.error = bus.valid && !known_addr && devmode_i;

    //////////////////////////////
    // configuration
    //////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            conf_q <= '0;
        end else if (conf_wr) begin
            for (int b = 0; b < `DESC64_DW/8; b++) begin
                if (bus.wstrb[b]) begin
                    conf_q[b*8 +: 8] <= bus.wdata[b*8 +: 8];   // per byte lane.
                end
            end
        end
    end

    //////////////////////////////
    // descriptor address
    //////////////////////////////

    // the whole word is taken, strobes do not apply here.
    always_ff @(posedge clk_i) begin
        if (desc_wr) begin
            desc_addr_q <= bus.wdata;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            desc_addr_qe_q <= 1'b0;
        end else begin
            desc_addr_qe_q <= desc_wr;            // one cycle after the write.
        end
    end

    assign desc_addr_o    = desc_addr_q;
    assign desc_addr_qe_o = desc_addr_qe_q;

    //////////////////////////////
    // completion counter
    //////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_cnt_q <= '0;
        end else if (desc_done_i) begin
            done_cnt_q <= done_cnt_q + 1'b1;
        end
    end

endmodule

/* rtl/desc64_reg_if.sv */
//////////////////////////////
// register bus interface with requester and
// completer modports.
//////////////////////////////

`timescale 1ns/1ps

interface desc64_reg_if;

    logic                  valid;   // request present.
    logic                  ready;   // completer takes it this cycle.
    desc64_pkg::reg_addr_t addr;
    logic                  write;   // 1 for write, 0 for read.
    desc64_pkg::reg_data_t wdata;
    desc64_pkg::reg_strb_t wstrb;
    desc64_pkg::reg_data_t rdata;   // valid in the handshake cycle.
    logic                  error;   // valid in the handshake cycle.

    modport requester (
        output valid, addr, write, wdata, wstrb,
        input  ready, rdata, error
    );

    modport completer (
        input  valid, addr, write, wdata, wstrb,
        output ready, rdata, error
    );

endinterface

/* rtl/desc64_reg_wrapper.sv */
//////////////////////////////
// back-pressure wrapper between the register bus
// and the register file, with the held push flag.
//////////////////////////////

`timescale 1ns/1ps
`include "desc64_cfg.svh"

module desc64_reg_wrapper (
    input  logic            clk_i,
    input  logic            arst_n_i,
    desc64_reg_if.completer outer,
    desc64_reg_if.requester inner,
    input  logic            desc_addr_qe_i,
    input  logic            desc_push_ready_i,
    output logic            desc_push_valid_o
);

    logic is_desc;        // request targets the descriptor address.
    logic desc_gate;      // queue can take a new descriptor.
    logic push_held_q;

    assign is_desc = (outer.addr == `DESC64_DESC_ADDR_OFFSET);

    // a push is pending from the strobe cycle until the queue accepts it.
    assign desc_push_valid_o = desc_addr_qe_i || push_held_q;
    assign desc_gate         = desc_push_ready_i && !desc_push_valid_o;

    //////////////////////////////
    // request and response
    //////////////////////////////

    assign inner.valid = is_desc ? (outer.valid && desc_gate) : outer.valid;
    assign outer.ready = is_desc ? (inner.ready && desc_gate) : inner.ready;

    assign inner.addr  = outer.addr;
    assign inner.write = outer.write;
    assign inner.wdata = outer.wdata;
    assign inner.wstrb = outer.wstrb;
    assign outer.rdata = inner.rdata;
    assign outer.error = inner.error;

    //////////////////////////////
    // held push
    //////////////////////////////

    // keeps a strobe that met a full queue alive until ready returns.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            push_held_q <= 1'b0;
        end else if (desc_addr_qe_i && !desc_push_ready_i) begin
            push_held_q <= 1'b1;
        end else if (desc_push_ready_i) begin
            push_held_q <= 1'b0;                  // push taken this edge.
        end
    end

endmodule
